//--- verilog/card_pkg.sv
package card_pkg;

    localparam int CARD_W = 8;                // bits per card

    // rank sits in the upper nibble, suit in the lower one
    typedef logic [CARD_W-1:0] card_t;

    typedef logic [3:0] rank_t;               // card rank only

    // high byte holds the upper card, low byte the lower-slot card
    typedef logic [2*CARD_W-1:0] rsp_word_t;

    // nothing to beat with a single
    localparam rsp_word_t RSP_PASS_SINGLE = 16'h00F0;

    // no pair above the opponent
    localparam rsp_word_t RSP_PASS_PAIR = 16'hF0F0;

    // pull the rank out of a card
    function automatic rank_t card_rank(input card_t card);
        return card[7:4];                     // upper nibble
    endfunction

endpackage

//--- verilog/play_pkg.sv
package play_pkg;

    // what the opponent led with
    typedef enum logic {
        PLAY_SINGLE = 1'b0,                   // one card
        PLAY_PAIR   = 1'b1                    // two equal ranks
    } play_kind_e;

    // search FSM of the scanner
    typedef enum logic [1:0] {
        SCAN_IDLE   = 2'd0,                   // waiting for a request
        SCAN_RUN    = 2'd1,                   // one slot per cycle
        SCAN_REPORT = 2'd2                    // result pulse
    } scan_state_e;

endpackage

//--- verilog/play_ifs.sv
`timescale 1ns/1ns

// slot read port of the hand store
interface hand_rd_if
    import card_pkg::*;
#(
    parameter int HAND_SLOTS = 17
) ();

    localparam int SLOT_W = $clog2(HAND_SLOTS + 1);   // enough to count all slots

    logic [SLOT_W-1:0] slot;                  // slot under test
    card_t             card_lo;               // card at slot
    card_t             card_hi;               // card at slot+1, zero past the end
    logic              free_lo;               // slot not played yet
    logic              free_hi;               // slot+1 not played yet

    modport scanner (
        output slot,
        input  card_lo,
        input  card_hi,
        input  free_lo,
        input  free_hi
    );

    modport store (
        input  slot,
        output card_lo,
        output card_hi,
        output free_lo,
        output free_hi
    );

endinterface

// search result from scanner to commit stage
interface scan_res_if
    import card_pkg::*;
    import play_pkg::*;
#(
    parameter int HAND_SLOTS = 17
) ();

    localparam int SLOT_W = $clog2(HAND_SLOTS + 1);

    logic              res_valid;             // one-cycle pulse
    logic              res_found;             // hit, else pass
    play_kind_e        res_kind;              // kind of the request
    logic [SLOT_W-1:0] res_slot;              // lowest slot of the play
    rsp_word_t         res_cards;             // {slot+1, slot}

    modport producer (
        output res_valid,
        output res_found,
        output res_kind,
        output res_slot,
        output res_cards
    );

    modport consumer (
        input  res_valid,
        input  res_found,
        input  res_kind,
        input  res_slot,
        input  res_cards
    );

endinterface

//--- verilog/card_hand_store.sv
`timescale 1ns/1ns

module card_hand_store
    import card_pkg::*;
#(
    parameter int HAND_SLOTS = 17
) (
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  logic                         deal_valid,     // load a fresh hand
    input  logic [HAND_SLOTS*CARD_W-1:0] deal_cards,     // slot 0 in the low byte
    hand_rd_if.store                     rd,
    input  logic                         mark_valid,     // cards leave the hand
    input  logic [$clog2(HAND_SLOTS+1)-1:0] mark_slot,
    input  logic                         mark_pair       // also slot+1
);

    localparam int SLOT_W = $clog2(HAND_SLOTS + 1);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(HAND_SLOTS - 1);

    card_t             hand [HAND_SLOTS];    // dealt cards
    logic [HAND_SLOTS-1:0] played;           // one bit per slot, 1 = gone
    logic [SLOT_W-1:0] slot_hi;              // neighbour of the read slot
    logic              hi_ok;                // neighbour exists

    // hand contents, only changed by a deal
    always_ff @(posedge sys_clk) begin
        if (deal_valid) begin
            for (int i = 0; i < HAND_SLOTS; i++) begin
                hand[i] <= deal_cards[i*CARD_W +: CARD_W];
            end
        end
    end

    // played mask
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            played <= '0;                    // everything free
        end else if (deal_valid) begin
            played <= '0;                    // new hand, all back
        end else if (mark_valid) begin
            played[mark_slot] <= 1'b1;
            if (mark_pair) begin
                played[mark_slot + 1'b1] <= 1'b1;  // second card of the pair
            end
        end
    end

    // combinational read port
    assign slot_hi    = rd.slot + 1'b1;
    assign hi_ok      = (rd.slot < LAST_SLOT);     // last slot has no neighbour
    assign rd.card_lo = hand[rd.slot];
    assign rd.free_lo = !played[rd.slot];
    assign rd.card_hi = hi_ok ? hand[slot_hi] : '0;
    assign rd.free_hi = hi_ok && !played[slot_hi];

    // scanner only reports free cards, so a mark must land on free slots
    mark_free_a : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        mark_valid |-> !played[mark_slot] && !(mark_pair && played[mark_slot + 1'b1])
    );

endmodule

//--- verilog/play_scanner.sv
`timescale 1ns/1ns

module play_scanner
    import card_pkg::*;
    import play_pkg::*;
#(
    parameter int HAND_SLOTS = 17
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       req_valid,            // request pulse
    input  play_kind_e req_kind,             // single or pair
    input  card_t      opp_card,             // card to beat
    hand_rd_if.scanner rd,
    scan_res_if.producer res,
    output logic       busy                  // search in progress
);

    localparam int SLOT_W = $clog2(HAND_SLOTS + 1);
    localparam logic [SLOT_W-1:0] LAST_SINGLE = SLOT_W'(HAND_SLOTS - 1);
    localparam logic [SLOT_W-1:0] LAST_PAIR   = SLOT_W'(HAND_SLOTS - 2);

    scan_state_e       state;
    play_kind_e        kind_q;               // captured request kind
    rank_t             opp_rank_q;           // captured opponent rank
    logic [SLOT_W-1:0] slot_q;               // slot under test
    logic              res_valid_q;
    logic              res_found_q;
    logic [SLOT_W-1:0] res_slot_q;
    rsp_word_t         res_cards_q;
    rank_t             rank_lo;
    rank_t             rank_hi;
    logic              single_hit;           // card beats opponent and is free
    logic              pair_hit;             // plus equal free neighbour
    logic              slot_hit;
    logic              slot_last;            // end of search range

    assign rd.slot = slot_q;
    assign rank_lo = card_rank(rd.card_lo);
    assign rank_hi = card_rank(rd.card_hi);

    assign single_hit = rd.free_lo && (rank_lo > opp_rank_q);
    assign pair_hit   = single_hit && rd.free_hi && (rank_hi == rank_lo);
    assign slot_hit   = (kind_q == PLAY_PAIR) ? pair_hit : single_hit;
    // pairs stop one slot early
    assign slot_last  = (slot_q == ((kind_q == PLAY_PAIR) ? LAST_PAIR : LAST_SINGLE));

    assign busy = (state != SCAN_IDLE);

    // search FSM
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= SCAN_IDLE;
            kind_q      <= PLAY_SINGLE;
            slot_q      <= '0;
            res_valid_q <= 1'b0;
            res_found_q <= 1'b0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (req_valid) begin     // only accepted while idle
                        state  <= SCAN_RUN;
                        kind_q <= req_kind;
                        slot_q <= '0;        // start at the lowest slot
                    end
                end
                SCAN_RUN: begin
                    if (slot_hit || slot_last) begin
                        state       <= SCAN_REPORT;
                        res_valid_q <= 1'b1;
                        res_found_q <= slot_hit;   // miss at the last slot = pass
                    end else begin
                        slot_q <= slot_q + 1'b1;   // next slot
                    end
                end
                SCAN_REPORT: begin
                    state       <= SCAN_IDLE;
                    res_valid_q <= 1'b0;     // single-cycle pulse
                end
                default: begin
                    state       <= SCAN_IDLE;
                    res_valid_q <= 1'b0;
                end
            endcase
        end
    end

    // request and result payload
    always_ff @(posedge sys_clk) begin
        if (state == SCAN_IDLE && req_valid) begin
            opp_rank_q <= card_rank(opp_card);
        end
        if (state == SCAN_RUN && (slot_hit || slot_last)) begin
            res_slot_q  <= slot_q;
            res_cards_q <= {rd.card_hi, rd.card_lo};  // upper card in the high byte
        end
    end

    assign res.res_valid = res_valid_q;
    assign res.res_found = res_found_q;
    assign res.res_kind  = kind_q;
    assign res.res_slot  = res_slot_q;
    assign res.res_cards = res_cards_q;

    // result pulse belongs to the report cycle
    res_in_report_a : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        res_valid_q |-> (state == SCAN_REPORT)
    );

endmodule

//--- verilog/play_commit.sv
`timescale 1ns/1ns

module play_commit
    import card_pkg::*;
    import play_pkg::*;
#(
    parameter int HAND_SLOTS = 17
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    scan_res_if.consumer res,
    output logic       mark_valid,           // tell the store what left the hand
    output logic [$clog2(HAND_SLOTS+1)-1:0] mark_slot,
    output logic       mark_pair,
    output logic       rsp_valid,            // response pulse
    output rsp_word_t  rsp_cards             // response word
);

    localparam int SLOT_W = $clog2(HAND_SLOTS + 1);

    logic              is_pair;
    rsp_word_t         rsp_next;             // word to register
    logic              rsp_valid_q;
    rsp_word_t         rsp_cards_q;
    logic [SLOT_W-1:0] slot_w;

    assign is_pair = (res.res_kind == PLAY_PAIR);
    assign slot_w  = res.res_slot;

    // store updates at the same edge that raises rsp_valid
    assign mark_valid = res.res_valid && res.res_found;
    assign mark_slot  = slot_w;
    assign mark_pair  = is_pair;

    // response word by kind and hit
    always_comb begin
        if (!res.res_found) begin
            rsp_next = is_pair ? RSP_PASS_PAIR : RSP_PASS_SINGLE;
        end else if (is_pair) begin
            rsp_next = res.res_cards;        // both cards of the pair
        end else begin
            rsp_next = {8'h00, res.res_cards[7:0]};  // single in low byte
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= res.res_valid;    // one cycle behind the scanner
        end
    end

    always_ff @(posedge sys_clk) begin
        if (res.res_valid) begin
            rsp_cards_q <= rsp_next;
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp_cards = rsp_cards_q;

    // scan takes at least three cycles, so responses never run back to back
    rsp_single_pulse_a : assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        rsp_valid_q |=> !rsp_valid_q
    );

endmodule

//--- verilog/poker_responder.sv
`timescale 1ns/1ns

module poker_responder
    import card_pkg::*;
    import play_pkg::*;
#(
    parameter int HAND_SLOTS = 17            // cards per hand
) (
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  logic                         deal_valid,    // deal pulse
    input  logic [HAND_SLOTS*CARD_W-1:0] deal_cards,    // flat hand, slot 0 lowest
    input  logic                         req_valid,     // request pulse
    input  play_kind_e                   req_kind,
    input  card_t                        opp_card,      // card to beat
    output logic                         rsp_valid,     // response pulse
    output rsp_word_t                    rsp_cards,
    output logic                         busy           // request in flight
);

    localparam int SLOT_W = $clog2(HAND_SLOTS + 1);

    logic              mark_valid;           // commit -> store
    logic [SLOT_W-1:0] mark_slot;
    logic              mark_pair;

    hand_rd_if  #(.HAND_SLOTS(HAND_SLOTS)) hand_rd  ();  // scanner reads the hand
    scan_res_if #(.HAND_SLOTS(HAND_SLOTS)) scan_res ();  // scanner -> commit

    // hand and played mask
    card_hand_store #(
        .HAND_SLOTS (HAND_SLOTS)
    ) u_store (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .deal_valid (deal_valid),
        .deal_cards (deal_cards),
        .rd         (hand_rd.store),
        .mark_valid (mark_valid),
        .mark_slot  (mark_slot),
        .mark_pair  (mark_pair)
    );

    // slot-by-slot search
    play_scanner #(
        .HAND_SLOTS (HAND_SLOTS)
    ) u_scanner (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .req_valid  (req_valid),
        .req_kind   (req_kind),
        .opp_card   (opp_card),
        .rd         (hand_rd.scanner),
        .res        (scan_res.producer),
        .busy       (busy)
    );

    // mark played cards, build the answer
    play_commit #(
        .HAND_SLOTS (HAND_SLOTS)
    ) u_commit (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .res        (scan_res.consumer),
        .mark_valid (mark_valid),
        .mark_slot  (mark_slot),
        .mark_pair  (mark_pair),
        .rsp_valid  (rsp_valid),
        .rsp_cards  (rsp_cards)
    );

endmodule

//--- test/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one-cycle deal pulse, only given while idle
task automatic deal_hand(input logic [HAND_SLOTS*CARD_W-1:0] cards);
    @(negedge sys_clk);
    deal_valid = 1'b1;
    deal_cards = cards;
    @(negedge sys_clk);
    deal_valid = 1'b0;                       // applied at the edge in between
endtask

// request pulse, busy must be low here and high one edge later
task automatic send_request(input play_kind_e kind, input card_t card);
    @(negedge sys_clk);
    assert (busy === 1'b0) else abort_run("request could not be sent, DUT still busy");
    req_valid = 1'b1;
    req_kind  = kind;
    opp_card  = card;
    req_count++;                             // accepted at the next edge
    @(negedge sys_clk);
    req_valid = 1'b0;
    assert (busy === 1'b1)
        else abort_run($sformatf("ERR %0t: busy is %b after an accepted request", $time, busy));
endtask

// extra request while busy, must not produce a response
task automatic poke_while_busy();
    req_valid = 1'b1;
    req_kind  = (req_kind == PLAY_SINGLE) ? PLAY_PAIR : PLAY_SINGLE;
    opp_card  = 8'h00;                       // would hit at once if taken
    @(negedge sys_clk);
    req_valid = 1'b0;
endtask

// wait for rsp_valid, bounded by the longest scan
task automatic wait_response(output rsp_word_t word);
    int waited;
    waited = 0;
    while (rsp_valid !== 1'b1 && waited < HAND_SLOTS + 4) begin
        @(negedge sys_clk);
        waited++;
    end
    assert (rsp_valid === 1'b1) else abort_run("no response arrived within the scan limit");
    assert (busy === 1'b0)
        else abort_run($sformatf("ERR %0t: busy still high in the response cycle", $time));
    word = rsp_cards;
endtask

`endif

//--- test/tb_poker_responder.sv
`timescale 1ns/1ns

module tb_poker_responder
    import card_pkg::*;
    import play_pkg::*;
();

    localparam int    HAND_SLOTS = 17;
    localparam int    CLK_NS     = 4;
    localparam int    RST_CYCLES = 10;
    localparam string INPUT_FILE = "test/play_input.txt";

    logic                         sys_clk;
    logic                         sys_rst_n;
    logic                         deal_valid;
    logic [HAND_SLOTS*CARD_W-1:0] deal_cards;
    logic                         req_valid;
    play_kind_e                   req_kind;
    card_t                        opp_card;
    logic                         rsp_valid;
    rsp_word_t                    rsp_cards;
    logic                         busy;

    int line_count  = 0;                     // lines in the input file
    int watchdog_ns = 0;
    int req_count   = 0;                     // accepted requests
    int rsp_count   = 0;                     // rsp_valid pulses seen

    poker_responder #(
        .HAND_SLOTS (HAND_SLOTS)
    ) dut0 (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .deal_valid (deal_valid),
        .deal_cards (deal_cards),
        .req_valid  (req_valid),
        .req_kind   (req_kind),
        .opp_card   (opp_card),
        .rsp_valid  (rsp_valid),
        .rsp_cards  (rsp_cards),
        .busy       (busy)
    );

    always #(CLK_NS / 2) sys_clk = ~sys_clk;  // 4 ns period

    // print the reason, then the fail message, then stop
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // hex number taken from fixed columns of a text line
    function automatic int hex_field(input string text, input int first, input int last);
        string field;
        field = text.substr(first, last);
        return field.atohex();
    endfunction

    `include "tb_tasks.svh"

    // every pulse spans exactly one falling edge
    always @(negedge sys_clk) begin
        if (sys_rst_n === 1'b1 && rsp_valid === 1'b1) begin
            rsp_count++;
        end
    end

    initial begin : watchdog
        wait (line_count > 0);
        #(watchdog_ns);
        abort_run("the run timed out before all input lines were processed");
    end

    initial begin : main_flow
        int                           fd;
        int                           n_lines;
        int                           lineno;
        string                        line;
        logic [HAND_SLOTS*CARD_W-1:0] hand;
        logic [3:0]                   kind_nib;
        card_t                        opp;
        rsp_word_t                    exp_word;
        rsp_word_t                    got_word;

        sys_clk    = 1'b0;
        sys_rst_n  = 1'b0;
        deal_valid = 1'b0;
        deal_cards = '0;
        req_valid  = 1'b0;
        req_kind   = PLAY_SINGLE;
        opp_card   = '0;

        fd = $fopen(INPUT_FILE, "r");
        assert (fd != 0) else abort_run("cannot open test/play_input.txt");
        n_lines = 0;
        while ($fgets(line, fd) > 0) begin
            n_lines++;
        end
        $fclose(fd);
        watchdog_ns = (n_lines * 30 + RST_CYCLES) * CLK_NS;
        line_count  = n_lines;               // arms the watchdog

        repeat (RST_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);
        assert (busy === 1'b0 && rsp_valid === 1'b0)
            else abort_run($sformatf("ERR %0t: busy=%b rsp_valid=%b after reset",
                                     $time, busy, rsp_valid));

        fd = $fopen(INPUT_FILE, "r");
        lineno = 0;
        while ($fgets(line, fd) > 0) begin
            lineno++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;                    // comment or blank
            end
            if (line.getc(0) == "D") begin
                assert (line.len() >= 3 * HAND_SLOTS + 1)
                    else abort_run($sformatf("deal on line %0d has too few cards", lineno));
                for (int i = 0; i < HAND_SLOTS; i++) begin
                    hand[i*CARD_W +: CARD_W] = CARD_W'(hex_field(line, 2 + 3*i, 3 + 3*i));
                end
                deal_hand(hand);
            end else if (line.getc(0) == "R") begin
                assert (line.len() >= 11)
                    else abort_run($sformatf("request on line %0d is incomplete", lineno));
                kind_nib = 4'(hex_field(line, 2, 2));
                opp      = card_t'(hex_field(line, 4, 5));
                exp_word = rsp_word_t'(hex_field(line, 7, 10));
                send_request(play_kind_e'(kind_nib[0]), opp);
                poke_while_busy();           // must be ignored
                wait_response(got_word);
                assert (got_word === exp_word)
                    else abort_run($sformatf("ERR %0t: line %0d response %h, expected %h",
                                             $time, lineno, got_word, exp_word));
            end else begin
                abort_run($sformatf("line %0d of the input file is not understood", lineno));
            end
        end
        $fclose(fd);

        repeat (HAND_SLOTS + 4) @(negedge sys_clk);  // room for a stray response
        if (rsp_count == req_count) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run($sformatf("ERR %0t: %0d responses for %0d accepted requests",
                                $time, rsp_count, req_count));
        end
    end

endmodule

//--- poker_responder.f
verilog/card_pkg.sv
verilog/play_pkg.sv
verilog/play_ifs.sv
verilog/card_hand_store.sv
verilog/play_scanner.sv
verilog/play_commit.sv
verilog/poker_responder.sv
+incdir+test
test/tb_poker_responder.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_poker_responder
FILELIST  ?= poker_responder.f
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- test/play_input.txt
# D line: 17 cards in hex, slot 0 first, one space apart
# R line: kind (0 single, 1 pair), opponent card, expected response word
D 32 51 53 71 94 96 A1 44 43 C2 C3 25 81 82 E1 62 37
R 0 40 0051
R 0 40 0053
R 0 40 0071
R 1 50 9694
R 1 50 C3C2
R 1 50 8281
R 1 50 F0F0
R 1 30 4344
R 0 D0 00E1
R 0 D0 00F0
R 0 00 0032
R 1 F0 F0F0
R 0 20 00A1
R 0 20 0062
R 0 20 0037
R 0 20 00F0
R 0 10 0025
D 32 51 53 71 94 96 A1 44 43 C2 C3 25 81 82 E1 62 37
R 0 40 0051
R 1 50 9694
R 1 30 4344
